// File: verilog.f
rtl/mips_isa_pkg.sv
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_fwd.sv
rtl/id_ex_pipe.sv
rtl/id_stage.sv
verif/tb_clk_gen.sv
verif/id_stage_chk.sv
verif/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - rtl/mips_isa_pkg.sv
      - rtl/id_pkg.sv
      - rtl/id_decoder.sv
      - rtl/id_operand_fwd.sv
      - rtl/id_ex_pipe.sv
      - rtl/id_stage.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/id_stage_chk.sv
      - verif/tb_id_stage.sv

// File: verif/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

	localparam int N_INST      = 400;
	localparam int CLK_NS      = 4;
	localparam int WATCHDOG_NS = (N_INST * 20 + 200) * CLK_NS;

	logic                     clk;
	logic                     arst_n;
	mips_isa_pkg::inst_t      inst;
	logic                     inst_valid;
	logic                     inst_ready;
	logic                     rf_re1;
	logic                     rf_re2;
	mips_isa_pkg::reg_addr_t  rf_raddr1;
	mips_isa_pkg::reg_addr_t  rf_raddr2;
	mips_isa_pkg::word_t      rf_rdata1;
	mips_isa_pkg::word_t      rf_rdata2;
	id_pkg::fwd_t             ex_fwd;
	id_pkg::fwd_t             mem_fwd;
	id_pkg::ex_req_t          ex_req;
	logic                     ex_valid;
	logic                     ex_ready;

	id_pkg::ex_req_t          exp_q[$];			// Expected bundles in issue order
	int                       err_cnt  = 0;
	int                       recv_cnt = 0;

	mips_isa_pkg::funct_t r_funct [0:9] = '{mips_isa_pkg::FN_OR, mips_isa_pkg::FN_AND,
		mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU,
		mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU};
	mips_isa_pkg::funct_t sh_funct [0:2] = '{mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
		mips_isa_pkg::FN_SRA};
	mips_isa_pkg::funct_t v_funct [0:2] = '{mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV,
		mips_isa_pkg::FN_SRAV};
	mips_isa_pkg::opcode_t i_opcode [0:7] = '{mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_ANDI,
		mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI, mips_isa_pkg::OP_SLTI,
		mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU};

	tb_clk_gen u_clk_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	id_stage UUT (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.inst_i       (inst),
		.inst_valid_i (inst_valid),
		.inst_ready_o (inst_ready),
		.rf_re1_o     (rf_re1),
		.rf_re2_o     (rf_re2),
		.rf_raddr1_o  (rf_raddr1),
		.rf_raddr2_o  (rf_raddr2),
		.rf_rdata1_i  (rf_rdata1),
		.rf_rdata2_i  (rf_rdata2),
		.ex_fwd_i     (ex_fwd),
		.mem_fwd_i    (mem_fwd),
		.ex_req_o     (ex_req),
		.ex_valid_o   (ex_valid),
		.ex_ready_i   (ex_ready)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Models and reference
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic mips_isa_pkg::word_t rf_model(input mips_isa_pkg::reg_addr_t addr);
		return (32'h9e37_79b9 * ({27'd0, addr} + 32'd1)) ^ {addr, 27'h2ab_cdef};
	endfunction

	assign rf_rdata1 = rf_model(rf_raddr1);		// Same-cycle read data
	assign rf_rdata2 = rf_model(rf_raddr2);

	function automatic mips_isa_pkg::word_t operand_value(input logic rd_en,
		input mips_isa_pkg::reg_addr_t addr, input mips_isa_pkg::word_t imm,
		input id_pkg::fwd_t ex, input id_pkg::fwd_t mem);
		if (!rd_en)
			return imm;
		if (ex.wreg && ex.wd == addr)
			return ex.wdata;
		if (mem.wreg && mem.wd == addr)
			return mem.wdata;
		return rf_model(addr);
	endfunction

	function automatic id_pkg::ex_req_t ref_decode(input mips_isa_pkg::inst_t w,
		input id_pkg::fwd_t ex, input id_pkg::fwd_t mem, output logic re1, output logic re2);
		id_pkg::ex_req_t      r;
		mips_isa_pkg::word_t  imm;
		mips_isa_pkg::word_t  zext;
		mips_isa_pkg::word_t  sext;
		logic                 ok;
		r    = '0;
		imm  = '0;
		re1  = 1'b0;
		re2  = 1'b0;
		ok   = 1'b1;
		zext = {16'h0000, w[15:0]};
		sext = {{16{w[15]}}, w[15:0]};
		r.wd = w[15:11];
		if (w[31:21] == 11'd0 && (w[5:0] == mips_isa_pkg::FN_SLL ||
			w[5:0] == mips_isa_pkg::FN_SRL || w[5:0] == mips_isa_pkg::FN_SRA))
		begin
			re2      = 1'b1;
			imm      = {27'd0, w[10:6]};			// Shift amount as operand 1
			r.alusel = id_pkg::SEL_SHIFT;
			r.aluop  = (w[5:0] == mips_isa_pkg::FN_SLL) ? id_pkg::ALUOP_SLL :
				(w[5:0] == mips_isa_pkg::FN_SRL) ? id_pkg::ALUOP_SRL : id_pkg::ALUOP_SRA;
		end
		else if (w[31:26] == mips_isa_pkg::OP_SPECIAL)
		begin
			re1 = 1'b1;
			re2 = 1'b1;
			ok  = (w[10:6] == 5'd0);
			case (w[5:0])
				mips_isa_pkg::FN_OR:   {r.aluop, r.alusel} = {id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC};
				mips_isa_pkg::FN_AND:  {r.aluop, r.alusel} = {id_pkg::ALUOP_AND, id_pkg::SEL_LOGIC};
				mips_isa_pkg::FN_XOR:  {r.aluop, r.alusel} = {id_pkg::ALUOP_XOR, id_pkg::SEL_LOGIC};
				mips_isa_pkg::FN_NOR:  {r.aluop, r.alusel} = {id_pkg::ALUOP_NOR, id_pkg::SEL_LOGIC};
				mips_isa_pkg::FN_SLLV: {r.aluop, r.alusel} = {id_pkg::ALUOP_SLL, id_pkg::SEL_SHIFT};
				mips_isa_pkg::FN_SRLV: {r.aluop, r.alusel} = {id_pkg::ALUOP_SRL, id_pkg::SEL_SHIFT};
				mips_isa_pkg::FN_SRAV: {r.aluop, r.alusel} = {id_pkg::ALUOP_SRA, id_pkg::SEL_SHIFT};
				mips_isa_pkg::FN_ADD:  {r.aluop, r.alusel} = {id_pkg::ALUOP_ADD, id_pkg::SEL_ARITH};
				mips_isa_pkg::FN_ADDU: {r.aluop, r.alusel} = {id_pkg::ALUOP_ADDU, id_pkg::SEL_ARITH};
				mips_isa_pkg::FN_SUB:  {r.aluop, r.alusel} = {id_pkg::ALUOP_SUB, id_pkg::SEL_ARITH};
				mips_isa_pkg::FN_SUBU: {r.aluop, r.alusel} = {id_pkg::ALUOP_SUBU, id_pkg::SEL_ARITH};
				mips_isa_pkg::FN_SLT:  {r.aluop, r.alusel} = {id_pkg::ALUOP_SLT, id_pkg::SEL_ARITH};
				mips_isa_pkg::FN_SLTU: {r.aluop, r.alusel} = {id_pkg::ALUOP_SLTU, id_pkg::SEL_ARITH};
				default:               ok = 1'b0;
			endcase
		end
		else
		begin
			re1  = 1'b1;
			r.wd = w[20:16];						// I-type writes rt
			case (w[31:26])
				mips_isa_pkg::OP_ORI:   {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC, zext};
				mips_isa_pkg::OP_ANDI:  {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_AND, id_pkg::SEL_LOGIC, zext};
				mips_isa_pkg::OP_XORI:  {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_XOR, id_pkg::SEL_LOGIC, zext};
				mips_isa_pkg::OP_LUI:   {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC, w[15:0], 16'h0000};
				mips_isa_pkg::OP_SLTI:  {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_SLT, id_pkg::SEL_ARITH, sext};
				mips_isa_pkg::OP_SLTIU: {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_SLTU, id_pkg::SEL_ARITH, sext};
				mips_isa_pkg::OP_ADDI:  {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_ADDI, id_pkg::SEL_ARITH, sext};
				mips_isa_pkg::OP_ADDIU: {r.aluop, r.alusel, imm} =
					{id_pkg::ALUOP_ADDIU, id_pkg::SEL_ARITH, sext};
				default:                ok = 1'b0;
			endcase
		end
		if (!ok)
		begin
			r.aluop  = id_pkg::ALUOP_NOP;
			r.alusel = id_pkg::SEL_NOP;
			re1      = 1'b0;
			re2      = 1'b0;
			imm      = '0;
		end
		r.wreg       = ok;
		r.inst_valid = ok;
		r.reg1       = operand_value(re1, w[25:21], imm, ex, mem);
		r.reg2       = operand_value(re2, w[20:16], imm, ex, mem);
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~

	// Registers stay in 0 to 7 so that the snoops hit often
	function automatic mips_isa_pkg::inst_t gen_inst();
		int unsigned              kind;
		mips_isa_pkg::reg_addr_t  rs;
		mips_isa_pkg::reg_addr_t  rt;
		mips_isa_pkg::reg_addr_t  rd;
		kind = $urandom_range(0, 9);
		rs   = 5'($urandom_range(0, 7));
		rt   = 5'($urandom_range(0, 7));
		rd   = 5'($urandom_range(0, 7));
		case (kind)
			0, 1, 2: return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, r_funct[$urandom_range(0, 9)]};
			3:       return {mips_isa_pkg::OP_SPECIAL, 5'd0, rt, rd, 5'($urandom),
				sh_funct[$urandom_range(0, 2)]};
			4:       return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, v_funct[$urandom_range(0, 2)]};
			5, 6, 7: return {i_opcode[$urandom_range(0, 7)], rs, rt, 16'($urandom)};
			8:       return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'($urandom_range(1, 31)),
				r_funct[$urandom_range(0, 9)]};		// Nonzero shamt is illegal
			default: return $urandom;				// Mostly unknown opcodes
		endcase
	endfunction

	function automatic id_pkg::fwd_t gen_fwd();
		id_pkg::fwd_t f;
		f.wreg  = 1'($urandom_range(0, 1));
		f.wd    = 5'($urandom_range(0, 7));
		f.wdata = $urandom;
		return f;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got_v,
		input logic [31:0] exp_v);
		if (got_v !== exp_v)
		begin
			err_cnt++;
			$display("error: %s got %h expected %h", name, got_v, exp_v);
		end
	endtask

	initial
	begin
		int          issued;
		int          taken;
		int          total;
		void'($urandom(32'hf14a_ac6f));
		issued     = 0;
		taken      = 0;
		inst       = '0;
		inst_valid = 1'b0;
		ex_fwd     = '0;
		mem_fwd    = '0;
		ex_ready   = 1'b0;
		@(posedge arst_n);
		@(posedge clk);
		check_value("ex_valid_o", 32'(ex_valid), 32'd0);
		check_value("inst_ready_o", 32'(inst_ready), 32'd1);
		while (taken < N_INST)
		begin
			if (inst_valid && inst_ready)
				taken++;
			if (!inst_valid || inst_ready)			// Hold the word while stalled
			begin
				if (issued < N_INST && $urandom_range(0, 4) != 0)
				begin
					inst       <= gen_inst();
					inst_valid <= 1'b1;
					issued++;
				end
				else
					inst_valid <= 1'b0;
			end
			ex_fwd   <= gen_fwd();
			mem_fwd  <= gen_fwd();
			ex_ready <= ($urandom_range(0, 3) != 0);
			@(posedge clk);
		end
		inst_valid <= 1'b0;
		ex_ready   <= 1'b1;
		while (recv_cnt < N_INST)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (exp_q.size() != 0)
		begin
			err_cnt++;
			$display("Expected bundles left over after the last output transfer");
		end
		total = err_cnt + UUT.u_chk.assert_fail_cnt;
		$display("Errors: %0d checks, %0d assertions", err_cnt, UUT.u_chk.assert_fail_cnt);
		if (total == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Scoreboard
	// ~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk)
	begin : push_expected
		id_pkg::ex_req_t exp_r;
		logic            re1;
		logic            re2;
		if (arst_n && inst_valid)
		begin
			exp_r = ref_decode(inst, ex_fwd, mem_fwd, re1, re2);
			check_value("rf_re1_o", 32'(rf_re1), 32'(re1));
			check_value("rf_re2_o", 32'(rf_re2), 32'(re2));
			check_value("rf_raddr1_o", 32'(rf_raddr1), 32'(inst[25:21]));
			check_value("rf_raddr2_o", 32'(rf_raddr2), 32'(inst[20:16]));
			if (inst_ready)
				exp_q.push_back(exp_r);
		end
	end

	always @(posedge clk)
	begin : compare_output
		id_pkg::ex_req_t exp_r;
		if (arst_n && ex_valid && ex_ready)
		begin
			if (exp_q.size() == 0)
			begin
				err_cnt++;
				$display("Output transfer with no instruction outstanding");
			end
			else
			begin
				exp_r = exp_q.pop_front();
				check_value("ex_req_o.inst_valid", 32'(ex_req.inst_valid), 32'(exp_r.inst_valid));
				check_value("ex_req_o.wreg", 32'(ex_req.wreg), 32'(exp_r.wreg));
				check_value("ex_req_o.aluop", 32'(ex_req.aluop), 32'(exp_r.aluop));
				check_value("ex_req_o.alusel", 32'(ex_req.alusel), 32'(exp_r.alusel));
				check_value("ex_req_o.reg1", ex_req.reg1, exp_r.reg1);
				check_value("ex_req_o.reg2", ex_req.reg2, exp_r.reg2);
				if (exp_r.inst_valid)
					check_value("ex_req_o.wd", 32'(ex_req.wd), 32'(exp_r.wd));
				recv_cnt++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Run timed out before all instructions came out of the stage");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/id_stage_chk.sv
`timescale 1ns/1ps

module id_stage_chk (
	input logic             clk,
	input logic             arst_n_i,
	input logic             inst_ready_o,
	input id_pkg::ex_req_t  ex_req_o,
	input logic             ex_valid_o,
	input logic             ex_ready_i
);

	int assert_fail_cnt = 0;					// Read by the testbench at the end

	// The slot is empty on the first edge out of reset
	reset_empty: assert property (@(posedge clk) $rose(arst_n_i) |-> !ex_valid_o)
		else begin assert_fail_cnt++; $error("ex_valid_o high after reset"); end

	// A stalled bundle keeps both its payload and its valid flag
	stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_req_o))
		else begin assert_fail_cnt++; $error("ex_req_o changed while stalled"); end

	empty_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
		!ex_valid_o |-> inst_ready_o)
		else begin assert_fail_cnt++; $error("inst_ready_o low with an empty slot"); end

endmodule

bind id_stage id_stage_chk u_chk (.*);

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	initial
	begin
		clk_o    = 1'b0;
		arst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;						// Released away from the active edge
	end

	always #2 clk_o = ~clk_o;					// 4 ns period

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                      clk,
	input  logic                      arst_n_i,

	input  mips_isa_pkg::inst_t       inst_i,
	input  logic                      inst_valid_i,
	output logic                      inst_ready_o,

	// Register file read ports
	output logic                      rf_re1_o,
	output logic                      rf_re2_o,
	output mips_isa_pkg::reg_addr_t   rf_raddr1_o,
	output mips_isa_pkg::reg_addr_t   rf_raddr2_o,
	input  mips_isa_pkg::word_t       rf_rdata1_i,
	input  mips_isa_pkg::word_t       rf_rdata2_i,

	input  id_pkg::fwd_t              ex_fwd_i,
	input  id_pkg::fwd_t              mem_fwd_i,

	output id_pkg::ex_req_t           ex_req_o,
	output logic                      ex_valid_o,
	input  logic                      ex_ready_i
);

	id_pkg::dec_t         dec;
	mips_isa_pkg::word_t  reg1;
	mips_isa_pkg::word_t  reg2;

	assign rf_re1_o    = dec.reg1_read;		// Straight from the current instruction
	assign rf_re2_o    = dec.reg2_read;
	assign rf_raddr1_o = dec.reg1_addr;
	assign rf_raddr2_o = dec.reg2_addr;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	id_operand_fwd u_operand_fwd (
		.dec_i       (dec),
		.rf_rdata1_i (rf_rdata1_i),
		.rf_rdata2_i (rf_rdata2_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2)
	);

	id_ex_pipe u_ex_pipe (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.dec_i        (dec),
		.reg1_i       (reg1),
		.reg2_i       (reg2),
		.inst_valid_i (inst_valid_i),
		.inst_ready_o (inst_ready_o),
		.ex_req_o     (ex_req_o),
		.ex_valid_o   (ex_valid_o),
		.ex_ready_i   (ex_ready_i)
	);

endmodule

// File: rtl/id_ex_pipe.sv
`timescale 1ns/1ps

module id_ex_pipe (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  id_pkg::dec_t         dec_i,
	input  mips_isa_pkg::word_t  reg1_i,
	input  mips_isa_pkg::word_t  reg2_i,
	input  logic                 inst_valid_i,
	output logic                 inst_ready_o,
	output id_pkg::ex_req_t      ex_req_o,
	output logic                 ex_valid_o,
	input  logic                 ex_ready_i
);

	logic load;

	assign inst_ready_o = !ex_valid_o || ex_ready_i;	// Free slot or it drains this cycle
	assign load         = inst_valid_i && inst_ready_o;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			ex_valid_o <= 1'b0;
		else if (inst_ready_o)
			ex_valid_o <= inst_valid_i;			// Drops when drained with nothing behind
	end

	// Payload only moves on a transfer, so a stall keeps it as is
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			ex_req_o.aluop      <= dec_i.aluop;
			ex_req_o.alusel     <= dec_i.alusel;
			ex_req_o.reg1       <= reg1_i;
			ex_req_o.reg2       <= reg2_i;
			ex_req_o.wd         <= dec_i.wd;
			ex_req_o.wreg       <= dec_i.wreg;
			ex_req_o.inst_valid <= dec_i.inst_valid;
		end
	end

endmodule

// File: rtl/id_operand_fwd.sv
`timescale 1ns/1ps

module id_operand_fwd (
	input  id_pkg::dec_t         dec_i,
	input  mips_isa_pkg::word_t  rf_rdata1_i,
	input  mips_isa_pkg::word_t  rf_rdata2_i,
	input  id_pkg::fwd_t         ex_fwd_i,
	input  id_pkg::fwd_t         mem_fwd_i,
	output mips_isa_pkg::word_t  reg1_o,
	output mips_isa_pkg::word_t  reg2_o
);

	// One source operand, the execute snoop is the younger result and wins
	function automatic mips_isa_pkg::word_t pick_operand(
		input logic                     rd_en,
		input mips_isa_pkg::reg_addr_t  addr,
		input mips_isa_pkg::word_t      rf_data,
		input mips_isa_pkg::word_t      imm,
		input id_pkg::fwd_t             ex,
		input id_pkg::fwd_t             mem
	);
		if (!rd_en)
			return imm;							// Immediate or shift amount
		else if (ex.wreg && ex.wd == addr)
			return ex.wdata;
		else if (mem.wreg && mem.wd == addr)
			return mem.wdata;
		else
			return rf_data;
	endfunction

	// Register 0 is matched like any other, the snoops never write it back
	always_comb
	begin
		reg1_o = pick_operand(dec_i.reg1_read, dec_i.reg1_addr, rf_rdata1_i,
			dec_i.imm, ex_fwd_i, mem_fwd_i);
		reg2_o = pick_operand(dec_i.reg2_read, dec_i.reg2_addr, rf_rdata2_i,
			dec_i.imm, ex_fwd_i, mem_fwd_i);
	end

endmodule

// File: rtl/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
	input  mips_isa_pkg::inst_t   inst_i,
	output id_pkg::dec_t          dec_o
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Instruction fields
	// ~~~~~~~~~~~~~~~~~~~~

	mips_isa_pkg::opcode_t    opcode;
	mips_isa_pkg::reg_addr_t  rs;
	mips_isa_pkg::reg_addr_t  rt;
	mips_isa_pkg::reg_addr_t  rd;
	mips_isa_pkg::shamt_t     shamt;
	mips_isa_pkg::funct_t     funct;
	mips_isa_pkg::imm16_t     imm16;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	// Function code table for the SPECIAL opcode
	id_pkg::alu_op_t   r_op;
	id_pkg::alu_sel_t  r_sel;
	logic              r_shimm;				// Shift by the shamt field

	always_comb
	begin
		r_op    = id_pkg::ALUOP_NOP;
		r_sel   = id_pkg::SEL_NOP;
		r_shimm = 1'b0;
		case (funct)
			mips_isa_pkg::FN_OR:   {r_op, r_sel} = {id_pkg::ALUOP_OR,   id_pkg::SEL_LOGIC};
			mips_isa_pkg::FN_AND:  {r_op, r_sel} = {id_pkg::ALUOP_AND,  id_pkg::SEL_LOGIC};
			mips_isa_pkg::FN_XOR:  {r_op, r_sel} = {id_pkg::ALUOP_XOR,  id_pkg::SEL_LOGIC};
			mips_isa_pkg::FN_NOR:  {r_op, r_sel} = {id_pkg::ALUOP_NOR,  id_pkg::SEL_LOGIC};
			mips_isa_pkg::FN_SLLV: {r_op, r_sel} = {id_pkg::ALUOP_SLL,  id_pkg::SEL_SHIFT};
			mips_isa_pkg::FN_SRLV: {r_op, r_sel} = {id_pkg::ALUOP_SRL,  id_pkg::SEL_SHIFT};
			mips_isa_pkg::FN_SRAV: {r_op, r_sel} = {id_pkg::ALUOP_SRA,  id_pkg::SEL_SHIFT};
			mips_isa_pkg::FN_ADD:  {r_op, r_sel} = {id_pkg::ALUOP_ADD,  id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_ADDU: {r_op, r_sel} = {id_pkg::ALUOP_ADDU, id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_SUB:  {r_op, r_sel} = {id_pkg::ALUOP_SUB,  id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_SUBU: {r_op, r_sel} = {id_pkg::ALUOP_SUBU, id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_SLT:  {r_op, r_sel} = {id_pkg::ALUOP_SLT,  id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_SLTU: {r_op, r_sel} = {id_pkg::ALUOP_SLTU, id_pkg::SEL_ARITH};
			mips_isa_pkg::FN_SLL:
			begin
				{r_op, r_sel} = {id_pkg::ALUOP_SLL, id_pkg::SEL_SHIFT};
				r_shimm       = 1'b1;
			end
			mips_isa_pkg::FN_SRL:
			begin
				{r_op, r_sel} = {id_pkg::ALUOP_SRL, id_pkg::SEL_SHIFT};
				r_shimm       = 1'b1;
			end
			mips_isa_pkg::FN_SRA:
			begin
				{r_op, r_sel} = {id_pkg::ALUOP_SRA, id_pkg::SEL_SHIFT};
				r_shimm       = 1'b1;
			end
			default:
			begin
				r_op  = id_pkg::ALUOP_NOP;		// Unknown function code stays invalid
				r_sel = id_pkg::SEL_NOP;
			end
		endcase
	end

	// Opcode table for the I-type instructions
	id_pkg::alu_op_t   i_op;
	id_pkg::alu_sel_t  i_sel;

	always_comb
	begin
		case (opcode)
			mips_isa_pkg::OP_ORI:   {i_op, i_sel} = {id_pkg::ALUOP_OR,    id_pkg::SEL_LOGIC};
			mips_isa_pkg::OP_ANDI:  {i_op, i_sel} = {id_pkg::ALUOP_AND,   id_pkg::SEL_LOGIC};
			mips_isa_pkg::OP_XORI:  {i_op, i_sel} = {id_pkg::ALUOP_XOR,   id_pkg::SEL_LOGIC};
			mips_isa_pkg::OP_LUI:   {i_op, i_sel} = {id_pkg::ALUOP_OR,    id_pkg::SEL_LOGIC};
			mips_isa_pkg::OP_SLTI:  {i_op, i_sel} = {id_pkg::ALUOP_SLT,   id_pkg::SEL_ARITH};
			mips_isa_pkg::OP_SLTIU: {i_op, i_sel} = {id_pkg::ALUOP_SLTU,  id_pkg::SEL_ARITH};
			mips_isa_pkg::OP_ADDI:  {i_op, i_sel} = {id_pkg::ALUOP_ADDI,  id_pkg::SEL_ARITH};
			mips_isa_pkg::OP_ADDIU: {i_op, i_sel} = {id_pkg::ALUOP_ADDIU, id_pkg::SEL_ARITH};
			default:                {i_op, i_sel} = {id_pkg::ALUOP_NOP,   id_pkg::SEL_NOP};
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Bundle assembly
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		dec_o.aluop      = id_pkg::ALUOP_NOP;
		dec_o.alusel     = id_pkg::SEL_NOP;
		dec_o.wd         = rd;					// R-type destination by default
		dec_o.wreg       = 1'b0;
		dec_o.reg1_read  = 1'b0;
		dec_o.reg2_read  = 1'b0;
		dec_o.reg1_addr  = rs;
		dec_o.reg2_addr  = rt;
		dec_o.imm        = '0;
		dec_o.inst_valid = 1'b0;

		if (opcode == mips_isa_pkg::OP_SPECIAL)
		begin
			if (r_shimm && rs == '0)
			begin
				// Bits 31 to 21 all zero, operand 1 carries the shift amount
				dec_o.reg2_read  = 1'b1;
				dec_o.imm        = {27'b0, shamt};
				dec_o.inst_valid = 1'b1;
			end
			else if (!r_shimm && r_sel != id_pkg::SEL_NOP && shamt == '0)
			begin
				dec_o.reg1_read  = 1'b1;
				dec_o.reg2_read  = 1'b1;
				dec_o.inst_valid = 1'b1;
			end
			dec_o.aluop = dec_o.inst_valid ? r_op : id_pkg::ALUOP_NOP;
			dec_o.alusel = dec_o.inst_valid ? r_sel : id_pkg::SEL_NOP;
		end
		else if (i_sel != id_pkg::SEL_NOP)
		begin
			dec_o.aluop      = i_op;
			dec_o.alusel     = i_sel;
			dec_o.wd         = rt;				// I-type writes rt
			dec_o.reg1_read  = 1'b1;			// lui reads rs as well, rs is zero in practice
			dec_o.inst_valid = 1'b1;
			if (opcode == mips_isa_pkg::OP_LUI)
				dec_o.imm = {imm16, 16'h0000};
			else if (i_sel == id_pkg::SEL_ARITH)
				dec_o.imm = {{16{imm16[15]}}, imm16};	// Compare and add sign-extend
			else
				dec_o.imm = {16'h0000, imm16};
		end

		dec_o.wreg = dec_o.inst_valid;			// Every kept instruction writes back
	end

endmodule

// File: rtl/id_pkg.sv
package id_pkg;

	typedef logic [7:0] alu_op_t;			// Sub-operation seen by execute
	typedef logic [2:0] alu_sel_t;			// Result class seen by execute

	// ~~~~~~~~~~~~~~~~~~~~
	// Operation codes
	// ~~~~~~~~~~~~~~~~~~~~

	localparam alu_op_t ALUOP_NOP   = 8'b00000000;
	localparam alu_op_t ALUOP_OR    = 8'b00100101;
	localparam alu_op_t ALUOP_AND   = 8'b00100100;
	localparam alu_op_t ALUOP_XOR   = 8'b00100110;
	localparam alu_op_t ALUOP_NOR   = 8'b00100111;
	localparam alu_op_t ALUOP_SLL   = 8'b01111100;
	localparam alu_op_t ALUOP_SRL   = 8'b00000010;
	localparam alu_op_t ALUOP_SRA   = 8'b00000011;
	localparam alu_op_t ALUOP_ADD   = 8'b00100000;
	localparam alu_op_t ALUOP_ADDU  = 8'b00100001;
	localparam alu_op_t ALUOP_SUB   = 8'b00100010;
	localparam alu_op_t ALUOP_SUBU  = 8'b00100011;
	localparam alu_op_t ALUOP_SLT   = 8'b00101010;	// Also used by slti
	localparam alu_op_t ALUOP_SLTU  = 8'b00101011;	// Also used by sltiu
	localparam alu_op_t ALUOP_ADDI  = 8'b01010101;
	localparam alu_op_t ALUOP_ADDIU = 8'b01010110;

	localparam alu_sel_t SEL_NOP   = 3'b000;
	localparam alu_sel_t SEL_LOGIC = 3'b001;
	localparam alu_sel_t SEL_SHIFT = 3'b010;
	localparam alu_sel_t SEL_ARITH = 3'b100;

	// ~~~~~~~~~~~~~~~~~~~~
	// Bundles
	// ~~~~~~~~~~~~~~~~~~~~

	// Write-back snoop from execute or memory
	typedef struct packed {
		logic                      wreg;
		mips_isa_pkg::reg_addr_t   wd;
		mips_isa_pkg::word_t       wdata;
	} fwd_t;

	typedef struct packed {
		alu_op_t                   aluop;
		alu_sel_t                  alusel;
		mips_isa_pkg::reg_addr_t   wd;			// Destination register
		logic                      wreg;		// Destination is written
		logic                      reg1_read;
		logic                      reg2_read;
		mips_isa_pkg::reg_addr_t   reg1_addr;
		mips_isa_pkg::reg_addr_t   reg2_addr;
		mips_isa_pkg::word_t       imm;			// Already extended
		logic                      inst_valid;
	} dec_t;

	typedef struct packed {
		alu_op_t                   aluop;
		alu_sel_t                  alusel;
		mips_isa_pkg::word_t       reg1;
		mips_isa_pkg::word_t       reg2;
		mips_isa_pkg::reg_addr_t   wd;
		logic                      wreg;
		logic                      inst_valid;
	} ex_req_t;

endpackage

// File: rtl/mips_isa_pkg.sv
package mips_isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Field types
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word_t;			// One data word
	typedef logic [31:0] inst_t;			// One instruction word
	typedef logic [4:0]  reg_addr_t;		// General purpose register number
	typedef logic [5:0]  opcode_t;			// Major opcode in bits 31 to 26
	typedef logic [5:0]  funct_t;			// Function code in bits 5 to 0
	typedef logic [4:0]  shamt_t;			// Shift amount in bits 10 to 6
	typedef logic [15:0] imm16_t;			// Immediate field of the I-type format

	// ~~~~~~~~~~~~~~~~~~~~
	// Major opcodes
	// ~~~~~~~~~~~~~~~~~~~~

	localparam opcode_t OP_SPECIAL = 6'b000000;	// R-type, decoded further by funct
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;

	// ~~~~~~~~~~~~~~~~~~~~
	// Function codes
	// ~~~~~~~~~~~~~~~~~~~~

	// Shifts by the shamt field
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;

	// Shifts by the low bits of rs
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;

	localparam funct_t FN_ADD  = 6'b100000;	// Traps on overflow in execute
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

endpackage
